// File: build.f
common/cache_pkg.sv
src/cache_req_decode.sv
tags/cache_tag_store.sv
wtbuf/cache_write_buffer.sv
src/cache_mem_port.sv
ctrl/cache_ctrl_regs.sv
src/cache_resp_merge.sv
src/cache_top.sv
tb/tb_cache_checker.sv
tb/tb_cache.sv

// File: common/cache_pkg.sv
package cache_pkg;

   localparam int ADDR_W      = 16;
   localparam int TAG_W       = 7;
   localparam int INDEX_W     = 6;
   localparam int OFFSET_W    = 2;
   localparam int CTRL_ADDR_W = 4;

   // Top bit selects the control register space.
   typedef union packed {
      struct packed {
         logic                space;
         logic [TAG_W-1:0]    tag;
         logic [INDEX_W-1:0]  index;
         logic [OFFSET_W-1:0] offset;
      } cache;
      struct packed {
         logic                          space;
         logic [ADDR_W-CTRL_ADDR_W-2:0] unused;
         logic [CTRL_ADDR_W-1:0]        reg_addr;
      } ctrl;
   } cache_addr_u;

   localparam logic [CTRL_ADDR_W-1:0] RW_HIT_ADDR     = 4'd0;
   localparam logic [CTRL_ADDR_W-1:0] RW_MISS_ADDR    = 4'd1;
   localparam logic [CTRL_ADDR_W-1:0] READ_HIT_ADDR   = 4'd2;
   localparam logic [CTRL_ADDR_W-1:0] READ_MISS_ADDR  = 4'd3;
   localparam logic [CTRL_ADDR_W-1:0] WRITE_HIT_ADDR  = 4'd4;
   localparam logic [CTRL_ADDR_W-1:0] WRITE_MISS_ADDR = 4'd5;
   localparam logic [CTRL_ADDR_W-1:0] RST_CNTRS_ADDR  = 4'd6;
   localparam logic [CTRL_ADDR_W-1:0] INVALIDATE_ADDR = 4'd7;
   localparam logic [CTRL_ADDR_W-1:0] WTB_EMPTY_ADDR  = 4'd8;
   localparam logic [CTRL_ADDR_W-1:0] WTB_FULL_ADDR   = 4'd9;
   localparam logic [CTRL_ADDR_W-1:0] VERSION_ADDR    = 4'd10;

   localparam logic [15:0] CACHE_VERSION = 16'h0101;

endpackage

// File: ctrl/cache_ctrl_regs.sv
`timescale 1ns/10ps

module cache_ctrl_regs #(
   parameter int DATA_W       = 32,
   parameter int USE_CTRL_CNT = 1
) (
   input  logic                              clk_i,
   input  logic                              reset,
   input  logic                              ctrl_valid,
   input  logic [cache_pkg::CTRL_ADDR_W-1:0] ctrl_addr,
   input  logic                              read_hit,
   input  logic                              read_miss,
   input  logic                              write_hit,
   input  logic                              write_miss,
   input  logic                              full,
   input  logic                              empty,
   output logic                              ctrl_ready,
   output logic [DATA_W-1:0]                 ctrl_rdata,
   output logic                              invalidate
);

   logic [DATA_W-1:0] read_hit_cnt;
   logic [DATA_W-1:0] read_miss_cnt;
   logic [DATA_W-1:0] write_hit_cnt;
   logic [DATA_W-1:0] write_miss_cnt;
   logic [DATA_W-1:0] rd_value;

   generate
      if (USE_CTRL_CNT != 0) begin : g_cnt
         logic clear_q;

         always_ff @(posedge clk_i or posedge reset) begin
            if (reset) begin
               clear_q        <= 1'b0;
               read_hit_cnt   <= '0;
               read_miss_cnt  <= '0;
               write_hit_cnt  <= '0;
               write_miss_cnt <= '0;
            end else begin
               // Clear lands at the end of the answer cycle.
               clear_q <= ctrl_valid && ctrl_addr == cache_pkg::RST_CNTRS_ADDR;
               if (clear_q) begin
                  read_hit_cnt   <= '0;
                  read_miss_cnt  <= '0;
                  write_hit_cnt  <= '0;
                  write_miss_cnt <= '0;
               end else if (read_hit) begin
                  read_hit_cnt <= read_hit_cnt + 1'b1;
               end else if (read_miss) begin
                  read_miss_cnt <= read_miss_cnt + 1'b1;
               end else if (write_hit) begin
                  write_hit_cnt <= write_hit_cnt + 1'b1;
               end else if (write_miss) begin
                  write_miss_cnt <= write_miss_cnt + 1'b1;
               end
            end
         end
      end else begin : g_no_cnt
         assign read_hit_cnt   = '0;
         assign read_miss_cnt  = '0;
         assign write_hit_cnt  = '0;
         assign write_miss_cnt = '0;
      end
   endgenerate

   always_comb begin
      case (ctrl_addr)
         cache_pkg::RW_HIT_ADDR:     rd_value = read_hit_cnt + write_hit_cnt;
         cache_pkg::RW_MISS_ADDR:    rd_value = read_miss_cnt + write_miss_cnt;
         cache_pkg::READ_HIT_ADDR:   rd_value = read_hit_cnt;
         cache_pkg::READ_MISS_ADDR:  rd_value = read_miss_cnt;
         cache_pkg::WRITE_HIT_ADDR:  rd_value = write_hit_cnt;
         cache_pkg::WRITE_MISS_ADDR: rd_value = write_miss_cnt;
         cache_pkg::WTB_EMPTY_ADDR:  rd_value = DATA_W'(empty);
         cache_pkg::WTB_FULL_ADDR:   rd_value = DATA_W'(full);
         cache_pkg::VERSION_ADDR:    rd_value = DATA_W'(cache_pkg::CACHE_VERSION);
         default:                    rd_value = '0;
      endcase
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         ctrl_ready <= 1'b0;
         ctrl_rdata <= '0;
         invalidate <= 1'b0;
      end else begin
         ctrl_ready <= ctrl_valid;
         ctrl_rdata <= ctrl_valid ? rd_value : '0;
         invalidate <= ctrl_valid && ctrl_addr == cache_pkg::INVALIDATE_ADDR;
      end
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds and runs the cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_cache \
   --Mdir obj_dir -o tb_cache_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

out=$(./obj_dir/tb_cache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^=== PASS ===$"; then
   exit 0
fi
exit 1

// File: src/cache_mem_port.sv
`timescale 1ns/10ps

module cache_mem_port #(
   parameter int DATA_W = 32
) (
   input  logic                         clk_i,
   input  logic                         reset,
   input  logic                         head_valid,
   input  logic [cache_pkg::ADDR_W-1:0] head_addr,
   input  logic [DATA_W-1:0]            head_data,
   input  logic                         refill_req,
   input  logic [cache_pkg::ADDR_W-1:0] refill_addr,
   input  logic                         mem_ready,
   input  logic [DATA_W-1:0]            mem_rdata,
   output logic                         pop,
   output logic                         refill_done,
   output logic [DATA_W-1:0]            refill_data,
   output logic                         mem_valid,
   output logic                         mem_we,
   output logic [cache_pkg::ADDR_W-1:0] mem_addr,
   output logic [DATA_W-1:0]            mem_wdata
);

   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_WRITE = 2'd1;
   localparam logic [1:0] ST_READ  = 2'd2;

   logic [1:0] state;

   assign pop         = state == ST_WRITE && mem_ready;
   assign refill_done = state == ST_READ && mem_ready;
   assign refill_data = mem_rdata;

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state     <= ST_IDLE;
         mem_valid <= 1'b0;
         mem_we    <= 1'b0;
         mem_addr  <= '0;
         mem_wdata <= '0;
      end else if (state == ST_IDLE) begin
         // Buffer drain goes before a refill.
         if (head_valid) begin
            state     <= ST_WRITE;
            mem_valid <= 1'b1;
            mem_we    <= 1'b1;
            mem_addr  <= head_addr;
            mem_wdata <= head_data;
         end else if (refill_req) begin
            state     <= ST_READ;
            mem_valid <= 1'b1;
            mem_we    <= 1'b0;
            mem_addr  <= refill_addr;
         end
      end else if (mem_ready) begin
         state     <= ST_IDLE;
         mem_valid <= 1'b0;
      end
   end

endmodule

// File: src/cache_req_decode.sv
`timescale 1ns/10ps

module cache_req_decode #(
   parameter int DATA_W = 32
) (
   input  logic                              clk_i,
   input  logic                              reset,
   input  logic                              req_valid,
   input  logic                              req_we,
   input  logic [cache_pkg::ADDR_W-1:0]      req_addr,
   input  logic [DATA_W-1:0]                 req_wdata,
   output logic                              cache_valid,
   output logic                              cache_we,
   output logic [cache_pkg::ADDR_W-1:0]      cache_addr,
   output logic [DATA_W-1:0]                 cache_wdata,
   output logic                              ctrl_valid,
   output logic [cache_pkg::CTRL_ADDR_W-1:0] ctrl_addr
);

   cache_pkg::cache_addr_u       req_view;
   logic                         held_we;
   logic [cache_pkg::ADDR_W-1:0] held_addr;
   logic [DATA_W-1:0]            held_wdata;

   assign req_view    = req_addr;
   assign cache_valid = req_valid & ~req_view.cache.space;
   assign ctrl_valid  = req_valid & req_view.ctrl.space;
   assign ctrl_addr   = req_view.ctrl.reg_addr;

   // Cache fields stay stable while the tag store stalls.
   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         held_we    <= 1'b0;
         held_addr  <= '0;
         held_wdata <= '0;
      end else if (cache_valid) begin
         held_we    <= req_we;
         held_addr  <= req_addr;
         held_wdata <= req_wdata;
      end
   end

   assign cache_we    = cache_valid ? req_we : held_we;
   assign cache_addr  = cache_valid ? req_addr : held_addr;
   assign cache_wdata = cache_valid ? req_wdata : held_wdata;

endmodule

// File: src/cache_resp_merge.sv
`timescale 1ns/10ps

module cache_resp_merge #(
   parameter int DATA_W = 32
) (
   input  logic              clk_i,
   input  logic              reset,
   input  logic              req_valid,
   input  logic              cache_ready,
   input  logic [DATA_W-1:0] cache_rdata,
   input  logic              ctrl_ready,
   input  logic [DATA_W-1:0] ctrl_rdata,
   output logic              resp_ready,
   output logic [DATA_W-1:0] resp_rdata
);

   logic busy;

   // One request in flight at a time.
   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         busy <= 1'b0;
      end else if (req_valid) begin
         busy <= 1'b1;
      end else if (resp_ready) begin
         busy <= 1'b0;
      end
   end

   assign resp_ready = busy & (cache_ready | ctrl_ready);
   assign resp_rdata = !resp_ready ? '0 : (ctrl_ready ? ctrl_rdata : cache_rdata);

endmodule

// File: src/cache_top.sv
`timescale 1ns/10ps

module cache_top #(
   parameter int DATA_W       = 32,
   parameter int WBUF_DEPTH   = 4,
   parameter int USE_CTRL_CNT = 1
) (
   input  logic                         clk_i,
   input  logic                         reset,
   input  logic                         req_valid,
   input  logic                         req_we,
   input  logic [cache_pkg::ADDR_W-1:0] req_addr,
   input  logic [DATA_W-1:0]            req_wdata,
   output logic                         resp_ready,
   output logic [DATA_W-1:0]            resp_rdata,
   output logic                         mem_valid,
   output logic                         mem_we,
   output logic [cache_pkg::ADDR_W-1:0] mem_addr,
   output logic [DATA_W-1:0]            mem_wdata,
   input  logic                         mem_ready,
   input  logic [DATA_W-1:0]            mem_rdata
);

   logic                              cache_valid;
   logic                              cache_we;
   logic [cache_pkg::ADDR_W-1:0]      cache_addr;
   logic [DATA_W-1:0]                 cache_wdata;
   logic                              ctrl_valid;
   logic [cache_pkg::CTRL_ADDR_W-1:0] ctrl_addr;
   logic                              cache_ready;
   logic [DATA_W-1:0]                 cache_rdata;
   logic                              read_hit;
   logic                              read_miss;
   logic                              write_hit;
   logic                              write_miss;
   logic                              push;
   logic [cache_pkg::ADDR_W-1:0]      push_addr;
   logic [DATA_W-1:0]                 push_data;
   logic                              refill_req;
   logic [cache_pkg::ADDR_W-1:0]      refill_addr;
   logic                              refill_done;
   logic [DATA_W-1:0]                 refill_data;
   logic                              head_valid;
   logic [cache_pkg::ADDR_W-1:0]      head_addr;
   logic [DATA_W-1:0]                 head_data;
   logic                              pop;
   logic                              full;
   logic                              empty;
   logic                              ctrl_ready;
   logic [DATA_W-1:0]                 ctrl_rdata;
   logic                              invalidate;

   // Port names match the wires above.
   cache_req_decode #(.DATA_W(DATA_W)) u_decode (.*);

   cache_tag_store #(.DATA_W(DATA_W)) u_tags (.*);

   cache_write_buffer #(
      .DATA_W    (DATA_W),
      .WBUF_DEPTH(WBUF_DEPTH)
   ) u_wtbuf (.*);

   cache_mem_port #(.DATA_W(DATA_W)) u_mem_port (.*);

   cache_ctrl_regs #(
      .DATA_W      (DATA_W),
      .USE_CTRL_CNT(USE_CTRL_CNT)
   ) u_ctrl (.*);

   cache_resp_merge #(.DATA_W(DATA_W)) u_merge (.*);

endmodule

// File: tags/cache_tag_store.sv
`timescale 1ns/10ps

module cache_tag_store #(
   parameter int DATA_W = 32
) (
   input  logic                         clk_i,
   input  logic                         reset,
   input  logic                         cache_valid,
   input  logic                         cache_we,
   input  logic [cache_pkg::ADDR_W-1:0] cache_addr,
   input  logic [DATA_W-1:0]            cache_wdata,
   input  logic                         invalidate,
   input  logic                         full,
   input  logic                         pop,
   input  logic                         refill_done,
   input  logic [DATA_W-1:0]            refill_data,
   output logic                         cache_ready,
   output logic [DATA_W-1:0]            cache_rdata,
   output logic                         read_hit,
   output logic                         read_miss,
   output logic                         write_hit,
   output logic                         write_miss,
   output logic                         push,
   output logic [cache_pkg::ADDR_W-1:0] push_addr,
   output logic [DATA_W-1:0]            push_data,
   output logic                         refill_req,
   output logic [cache_pkg::ADDR_W-1:0] refill_addr
);

   localparam int LINES = 2 ** cache_pkg::INDEX_W;
   localparam logic [1:0] ST_IDLE   = 2'd0;
   localparam logic [1:0] ST_MISS   = 2'd1;
   localparam logic [1:0] ST_WSTALL = 2'd2;

   cache_pkg::cache_addr_u        addr_view;
   logic [LINES-1:0]              valid;
   logic [cache_pkg::TAG_W-1:0]   tag_mem  [LINES];
   logic [DATA_W-1:0]             data_mem [LINES];
   logic [1:0]                    state;
   logic                          hit;
   logic                          write_ok;

   assign addr_view = cache_addr;
   assign hit = valid[addr_view.cache.index]
                && tag_mem[addr_view.cache.index] == addr_view.cache.tag;

   assign read_hit   = cache_valid & ~cache_we & hit;
   assign read_miss  = cache_valid & ~cache_we & ~hit;
   assign write_hit  = cache_valid & cache_we & hit;
   assign write_miss = cache_valid & cache_we & ~hit;

   // A write goes to the buffer once a slot is free.
   assign write_ok = cache_we && ((state == ST_IDLE && cache_valid && !full)
                                  || (state == ST_WSTALL && pop));

   assign push_addr   = cache_addr;
   assign push_data   = cache_wdata;
   assign refill_addr = cache_addr;

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state       <= ST_IDLE;
         valid       <= '0;
         cache_ready <= 1'b0;
         push        <= 1'b0;
         refill_req  <= 1'b0;
      end else begin
         cache_ready <= 1'b0;
         push        <= write_ok;
         if (invalidate) begin
            valid <= '0;
         end
         case (state)
            ST_IDLE: begin
               if (cache_valid) begin
                  if (cache_we && full) begin
                     state <= ST_WSTALL;
                  end else if (cache_we || hit) begin
                     cache_ready <= 1'b1;
                  end else begin
                     state      <= ST_MISS;
                     refill_req <= 1'b1;
                  end
               end
            end
            ST_MISS: begin
               if (refill_done) begin
                  valid[addr_view.cache.index] <= 1'b1;
                  refill_req  <= 1'b0;
                  cache_ready <= 1'b1;
                  state       <= ST_IDLE;
               end
            end
            ST_WSTALL: begin
               if (pop) begin
                  cache_ready <= 1'b1;
                  state       <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state == ST_MISS && refill_done) begin
         tag_mem[addr_view.cache.index]  <= addr_view.cache.tag;
         data_mem[addr_view.cache.index] <= refill_data;
         cache_rdata                     <= refill_data;
      end else begin
         // No allocation on a write miss.
         if (write_ok && hit) begin
            data_mem[addr_view.cache.index] <= cache_wdata;
         end
         if (cache_valid) begin
            cache_rdata <= cache_we ? '0 : data_mem[addr_view.cache.index];
         end
      end
   end

endmodule

// File: tb/cache_testdata.txt
# op (R read, W write, C control read) addr wdata expected_rdata, all hex
# op addr wdata expected
R 0040 00000000 a5a50010
R 0040 00000000 a5a50010
C 8002 00000000 00000001
W 0040 12345678 00000000
R 0040 00000000 12345678
C 8004 00000000 00000001
W 0100 cafe0001 00000000
R 0100 00000000 cafe0001
W 0200 d0000000 00000000
W 0204 d0000001 00000000
W 0208 d0000002 00000000
W 020c d0000003 00000000
W 0210 d0000004 00000000
W 0214 d0000005 00000000
W 0218 d0000006 00000000
C 8009 00000000 00000001
R 0204 00000000 d0000001
C 8008 00000000 00000001
C 8000 00000000 00000003
C 8001 00000000 0000000b
C 8003 00000000 00000003
C 8005 00000000 00000008
C 800a 00000000 00000101
C 800f 00000000 00000000
C 8006 00000000 00000000
C 8000 00000000 00000000
C 8001 00000000 00000000
R 0040 00000000 12345678
C 8007 00000000 00000000
R 0040 00000000 12345678
C 8003 00000000 00000001
C 8002 00000000 00000001

// File: tb/tb_cache.sv
`timescale 1ns/10ps

module tb_cache;

   localparam int DATA_W = 32;

   logic              clk_i;
   logic              reset;
   logic              req_valid;
   logic              req_we;
   logic [15:0]       req_addr;
   logic [DATA_W-1:0] req_wdata;
   logic              resp_ready;
   logic [DATA_W-1:0] resp_rdata;
   logic              mem_valid;
   logic              mem_we;
   logic [15:0]       mem_addr;
   logic [DATA_W-1:0] mem_wdata;
   logic              mem_ready = 1'b0;
   logic [DATA_W-1:0] mem_rdata = '0;
   logic [DATA_W-1:0] exp_rdata;
   int                error_count;
   int                pending_writes;
   int                resp_count;

   logic [7:0]        op_list [$];
   logic [15:0]       addr_list [$];
   logic [DATA_W-1:0] wdata_list [$];
   logic [DATA_W-1:0] exp_list [$];

   logic [DATA_W-1:0] mem_words [int];
   logic              mem_busy = 1'b0;
   int                wait_cnt = 0;
   integer            seed = 94;
   int                cycle_cnt = 0;
   int                cycle_limit = 0;

   cache_top #(
      .DATA_W      (DATA_W),
      .WBUF_DEPTH  (4),
      .USE_CTRL_CNT(1)
   ) dut (.*);

   tb_cache_checker #(.DATA_W(DATA_W)) u_checker (.*);

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   function automatic logic [DATA_W-1:0] mem_read(input logic [15:0] addr);
      int idx;
      idx = int'(addr[15:2]);
      if (mem_words.exists(idx)) begin
         return mem_words[idx];
      end
      return DATA_W'(addr >> 2) ^ 32'hA5A50000;
   endfunction

   // Memory answers after 1 to 4 cycles.
   always @(posedge clk_i) begin
      mem_ready <= 1'b0;
      if (!reset && mem_valid && !mem_ready) begin
         if (!mem_busy) begin
            mem_busy <= 1'b1;
            wait_cnt <= int'($unsigned($random(seed)) % 4);
         end else if (wait_cnt == 0) begin
            mem_busy  <= 1'b0;
            mem_ready <= 1'b1;
            if (mem_we) begin
               mem_words[int'(mem_addr[15:2])] = mem_wdata;
            end else begin
               mem_rdata <= mem_read(mem_addr);
            end
         end else begin
            wait_cnt <= wait_cnt - 1;
         end
      end
   end

   always @(posedge clk_i) begin
      if (!reset) begin
         cycle_cnt <= cycle_cnt + 1;
         if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
            $display("=== FAIL ===");
            $finish;
         end
      end
   end

   task automatic load_requests();
      int    fd;
      int    n;
      string line;
      logic [7:0]        op;
      logic [15:0]       addr;
      logic [DATA_W-1:0] wdata;
      logic [DATA_W-1:0] expd;
      fd = $fopen("tb/cache_testdata.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the test data file tb/cache_testdata.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0) begin
               n = $sscanf(line, "%c %h %h %h", op, addr, wdata, expd);
               if (n == 4 && op != "#") begin
                  op_list.push_back(op);
                  addr_list.push_back(addr);
                  wdata_list.push_back(wdata);
                  exp_list.push_back(expd);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // Starts on a rising edge and returns on the edge after the response.
   task automatic issue_request(input int i);
      req_valid <= 1'b1;
      req_we    <= op_list[i] == "W";
      req_addr  <= addr_list[i];
      req_wdata <= wdata_list[i];
      exp_rdata <= exp_list[i];
      @(posedge clk_i);
      req_valid <= 1'b0;
      @(negedge clk_i);
      while (!resp_ready) begin
         @(negedge clk_i);
      end
      @(posedge clk_i);
   endtask

   initial begin
      int total;
      reset     = 1'b1;
      req_valid = 1'b0;
      req_we    = 1'b0;
      req_addr  = '0;
      req_wdata = '0;
      exp_rdata = '0;
      load_requests();
      cycle_limit = op_list.size() * 40 + 200;
      repeat (16) @(posedge clk_i);
      reset <= 1'b0;
      @(posedge clk_i);
      for (int i = 0; i < op_list.size(); i++) begin
         issue_request(i);
      end
      repeat (10) @(posedge clk_i);
      total = error_count;
      if (op_list.size() == 0) begin
         $display("No requests were loaded from the test data file");
         total = total + 1;
      end
      if (pending_writes != 0) begin
         $display("%0d CPU writes never reached memory", pending_writes);
         total = total + 1;
      end
      if (resp_count != op_list.size()) begin
         $display("Got %0d responses for %0d requests", resp_count, op_list.size());
         total = total + 1;
      end
      $display("Done: %0d requests, %0d responses, %0d errors",
               op_list.size(), resp_count, total);
      if (total == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// File: tb/tb_cache_checker.sv
`timescale 1ns/10ps

module tb_cache_checker #(
   parameter int DATA_W = 32
) (
   input  logic              clk_i,
   input  logic              reset,
   input  logic              req_valid,
   input  logic              req_we,
   input  logic [15:0]       req_addr,
   input  logic [DATA_W-1:0] req_wdata,
   input  logic              resp_ready,
   input  logic [DATA_W-1:0] resp_rdata,
   input  logic              mem_valid,
   input  logic              mem_we,
   input  logic [15:0]       mem_addr,
   input  logic [DATA_W-1:0] mem_wdata,
   input  logic              mem_ready,
   input  logic [DATA_W-1:0] mem_rdata,
   input  logic [DATA_W-1:0] exp_rdata,
   output int                error_count,
   output int                pending_writes,
   output int                resp_count
);

   logic [15:0]       wq_addr [$];
   logic [DATA_W-1:0] wq_data [$];
   logic [15:0]       last_addr = '0;
   int                errors = 0;
   int                responses = 0;
   int                queued = 0;

   assign error_count    = errors;
   assign pending_writes = queued;
   assign resp_count     = responses;

   always @(negedge clk_i) begin
      if (!reset) begin
         if (req_valid) begin
            last_addr <= req_addr;
            if (req_we && !req_addr[15]) begin
               wq_addr.push_back(req_addr);
               wq_data.push_back(req_wdata);
            end
         end
         if (resp_ready) begin
            responses <= responses + 1;
            if (resp_rdata !== exp_rdata) begin
               $display("MISMATCH at %0t: response %h for address %h, expected %h",
                        $time, resp_rdata, last_addr, exp_rdata);
               errors = errors + 1;
            end
         end else if (resp_rdata !== '0) begin
            $display("MISMATCH at %0t: read data %h outside a response", $time, resp_rdata);
            errors = errors + 1;
         end
         if (mem_valid && mem_ready && mem_we) begin
            if (wq_addr.size() == 0) begin
               $display("Memory write to %h at %0t has no pending CPU write", mem_addr, $time);
               errors = errors + 1;
            end else begin
               if (mem_addr !== wq_addr[0] || mem_wdata !== wq_data[0]) begin
                  $display("MISMATCH at %0t: memory write %h <= %h, expected %h <= %h",
                           $time, mem_addr, mem_wdata, wq_addr[0], wq_data[0]);
                  errors = errors + 1;
               end
               void'(wq_addr.pop_front());
               void'(wq_data.pop_front());
            end
         end else if (mem_valid && mem_ready) begin
            // A refill reads only after every earlier CPU write reached memory.
            if (wq_addr.size() != 0) begin
               $display("Memory read of %h at %0t started with %0d CPU writes still queued",
                        mem_addr, $time, wq_addr.size());
               errors = errors + 1;
            end
            if (mem_addr[15:2] !== last_addr[15:2]) begin
               $display("MISMATCH at %0t: memory read %h, expected a refill of %h",
                        $time, mem_addr, last_addr);
               errors = errors + 1;
            end
         end
         queued = wq_addr.size();
      end
   end

endmodule

// File: wtbuf/cache_write_buffer.sv
`timescale 1ns/10ps

module cache_write_buffer #(
   parameter int DATA_W     = 32,
   parameter int WBUF_DEPTH = 4
) (
   input  logic                         clk_i,
   input  logic                         reset,
   input  logic                         push,
   input  logic [cache_pkg::ADDR_W-1:0] push_addr,
   input  logic [DATA_W-1:0]            push_data,
   input  logic                         pop,
   output logic                         head_valid,
   output logic [cache_pkg::ADDR_W-1:0] head_addr,
   output logic [DATA_W-1:0]            head_data,
   output logic                         full,
   output logic                         empty
);

   localparam int PTR_W = $clog2(WBUF_DEPTH);

   logic [cache_pkg::ADDR_W-1:0] addr_mem [WBUF_DEPTH];
   logic [DATA_W-1:0]            data_mem [WBUF_DEPTH];
   logic [PTR_W-1:0]             rd_ptr;
   logic [PTR_W-1:0]             wr_ptr;
   logic [PTR_W:0]               count;

   assign empty      = count == '0;
   assign full       = count == WBUF_DEPTH;
   assign head_valid = ~empty;
   assign head_addr  = addr_mem[rd_ptr];
   assign head_data  = data_mem[rd_ptr];

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Pointers wrap at the power-of-two depth.
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         addr_mem[wr_ptr] <= push_addr;
         data_mem[wr_ptr] <= push_data;
      end
   end

endmodule
